// File: build.f
+incdir+sim
logic/csum_pkg.sv
logic/init_sequencer.sv
logic/lane_dispatch.sv
logic/csum_lane.sv
logic/lane_collect.sv
logic/csum_offload_top.sv
sim/tb_csum_offload.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the checksum offload testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_csum_offload \
  -f build.f -o tb_csum_offload
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_csum_offload > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "simulation log holds no final result"
  exit 1
fi
exit 0

// File: sim/tb_csum_ref.svh
`ifndef TB_CSUM_REF_SVH
`define TB_CSUM_REF_SVH

  // **********************************************************************
  // Reference checksum and typed compare tasks
  // **********************************************************************

  // Plain 32-bit sum of all words folded at the end
  function automatic csum_t ref_csum(input beat_data_t d [LANE_DEPTH],
                                     input beat_keep_t k [LANE_DEPTH],
                                     input int len);
    logic [31:0] total;
    logic [15:0] word;
    total = 32'h0;
    for (int b = 0; b < len; b++) begin
      for (int j = 0; j < DATA_W / 16; j++) begin
        word = 16'h0000;
        if (k[b][2*j])     word[7:0]  = d[b][16*j +: 8];       // Low byte of the word
        if (k[b][2*j + 1]) word[15:8] = d[b][16*j + 8 +: 8];
        // Checksum field itself is left out
        if (!((b == 0) && (j == 0))) total = total + {16'h0, word};
      end
    end
    while (total[31:16] != 16'h0) begin
      total = {16'h0, total[15:0]} + {16'h0, total[31:16]};
    end
    return total[15:0];
  endfunction

  task automatic check_data(input string what, input beat_data_t exp, input beat_data_t act);
    if (act !== exp) begin
      $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_keep(input string what, input beat_keep_t exp, input beat_keep_t act);
    if (act !== exp) begin
      $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_csum(input string what, input csum_t exp, input csum_t act);
    if (act !== exp) begin
      $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: %s expected %b actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("error %s: %s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

`endif

// File: sim/tb_csum_offload.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csum_offload
  import csum_pkg::*;
();

  logic       mig_clk;
  logic       rst_i;
  logic       ddr_init_complete_i;
  logic       init_done_o;
  logic       s_valid_i;
  beat_data_t s_data_i;
  beat_keep_t s_keep_i;
  logic       s_last_i;
  logic       s_ready_o;
  logic       m_valid_o;
  beat_data_t m_data_o;
  beat_keep_t m_keep_o;
  logic       m_last_o;
  logic       m_ready_i;

  // Expected output with one entry per beat
  beat_data_t exp_data [$];
  beat_keep_t exp_keep [$];
  logic       exp_last [$];
  csum_t      exp_csum [$];   // One per packet
  beat_data_t pkt_data [LANE_DEPTH];
  beat_keep_t pkt_keep [LANE_DEPTH];

  string      test_name;
  int         test_errs;
  int         total_errs;
  int         tests_run;
  int         tests_failed;
  int         stall_cnt;      // Cycles an offered input beat waited
  int         edges;
  logic       random_ready;
  logic       out_first;

  `include "tb_csum_ref.svh"

  csum_offload_top dut (
    .mig_clk             (mig_clk),
    .rst_i               (rst_i),
    .ddr_init_complete_i (ddr_init_complete_i),
    .init_done_o         (init_done_o),
    .s_valid_i           (s_valid_i),
    .s_data_i            (s_data_i),
    .s_keep_i            (s_keep_i),
    .s_last_i            (s_last_i),
    .s_ready_o           (s_ready_o),
    .m_valid_o           (m_valid_o),
    .m_data_o            (m_data_o),
    .m_keep_o            (m_keep_o),
    .m_last_o            (m_last_o),
    .m_ready_i           (m_ready_i)
  );

  always #20 mig_clk = ~mig_clk;

  // Random output back-pressure holds off about one cycle in four
  always @(posedge mig_clk) begin
    #2;
    if (random_ready) m_ready_i = (($urandom % 4) != 0);
    else m_ready_i = 1'b1;
  end

  // **********************************************************************
  // Output monitor sampling mid-cycle where outputs are settled
  // **********************************************************************
  always @(negedge mig_clk) begin
    if (!rst_i && m_valid_o && m_ready_i) begin
      if (exp_data.size() == 0) begin
        $display("unexpected output beat in %s, no packet was pending", test_name);
        test_errs++;
      end else begin
        if (out_first) check_csum("checksum field", exp_csum.pop_front(), m_data_o[CSUM_W-1:0]);
        check_data("data", exp_data.pop_front(), m_data_o);
        check_keep("keep", exp_keep.pop_front(), m_keep_o);
        check_flag("last", exp_last.pop_front(), m_last_o);
        out_first = m_last_o;
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("%s in test %s", reason, test_name);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      total_errs += test_errs;
      $display("test %s: FAIL with %0d errors", test_name, test_errs);
    end else begin
      $display("test %s: pass", test_name);
    end
  endtask

  // Starts 2 ns after a rising edge and returns 2 ns after the transfer edge
  task automatic drive_beat(input beat_data_t d, input beat_keep_t k, input logic l);
    int waited;
    waited = 0;
    s_valid_i = 1'b1;
    s_data_i  = d;
    s_keep_i  = k;
    s_last_i  = l;
    @(negedge mig_clk);
    while (!s_ready_o) begin
      stall_cnt++;
      waited++;
      if (waited > 1000) abort_run("input beat was never accepted");
      @(negedge mig_clk);
    end
    @(posedge mig_clk);
    #2;
  endtask

  task automatic send_packet(input int len, input beat_keep_t last_keep);
    csum_t sum;
    for (int b = 0; b < len; b++) begin
      pkt_data[b] = {$urandom, $urandom};
      pkt_keep[b] = (b == len - 1) ? last_keep : '1;
    end
    sum = ref_csum(pkt_data, pkt_keep, len);
    exp_csum.push_back(~sum);
    for (int b = 0; b < len; b++) begin
      exp_data.push_back((b == 0) ? {pkt_data[b][DATA_W-1:CSUM_W], ~sum} : pkt_data[b]);
      exp_keep.push_back(pkt_keep[b]);
      exp_last.push_back(b == len - 1);
    end
    for (int b = 0; b < len; b++) begin
      drive_beat(pkt_data[b], pkt_keep[b], b == len - 1);
    end
  endtask

  task automatic idle_input();
    s_valid_i = 1'b0;
    s_last_i  = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      waited++;
      if (waited > 3000) abort_run("output packets did not drain");
      @(posedge mig_clk);
    end
    repeat (4) @(posedge mig_clk);   // Let credits return
    #2;
  endtask

  // **********************************************************************
  // Test sequence
  // **********************************************************************
  initial begin
    void'($urandom(32'h3e74_e61b));
    mig_clk             = 1'b0;
    rst_i               = 1'b1;
    ddr_init_complete_i = 1'b0;
    s_valid_i           = 1'b0;
    s_data_i            = '0;
    s_keep_i            = '0;
    s_last_i            = 1'b0;
    m_ready_i           = 1'b1;
    random_ready        = 1'b0;
    out_first           = 1'b1;
    tests_run           = 0;
    tests_failed        = 0;
    total_errs          = 0;
    stall_cnt           = 0;
    repeat (4) @(posedge mig_clk);
    #2;
    rst_i = 1'b0;

    start_test("init_timing");
    repeat (10) begin
      @(negedge mig_clk);
      check_flag("s_ready_o before init", 1'b0, s_ready_o);
      check_flag("init_done_o before init", 1'b0, init_done_o);
    end
    @(posedge mig_clk);
    #2;
    ddr_init_complete_i = 1'b1;
    @(posedge mig_clk);              // First edge that sees init complete
    edges = 0;
    @(negedge mig_clk);
    while (!init_done_o) begin
      check_flag("s_ready_o during init wait", 1'b0, s_ready_o);
      edges++;
      if (edges > 100) abort_run("init_done_o never rose");
      @(negedge mig_clk);
    end
    check_count("init_done_o delay in cycles", INIT_WAIT, edges);
    @(posedge mig_clk);
    #2;
    end_test();

    start_test("single_beat");
    send_packet(1, 8'hff);
    idle_input();
    wait_drain();
    end_test();

    start_test("partial_keep");
    for (int i = 0; i < 4; i++) begin
      send_packet(2 + i, beat_keep_t'(8'hff >> (2*i + 1)));   // 7f, 1f, 07, 01
    end
    idle_input();
    wait_drain();
    end_test();

    start_test("random_backpressure");
    random_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      send_packet(int'($urandom_range(1, LANE_DEPTH)), beat_keep_t'($urandom_range(1, 255)));
    end
    idle_input();
    wait_drain();
    random_ready = 1'b0;
    end_test();

    // Full-size packets drain each lane's credits completely
    start_test("full_depth");
    stall_cnt = 0;
    for (int i = 0; i < 6; i++) begin
      send_packet(LANE_DEPTH, '1);
    end
    idle_input();
    wait_drain();
    check_count("input stall cycles", 0, stall_cnt);
    end_test();

    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/csum_offload_top.sv
`timescale 1ns/1ns
`default_nettype none

module csum_offload_top
  import csum_pkg::*;
(
  input  wire        mig_clk,
  input  wire        rst_i,
  input  wire        ddr_init_complete_i,
  output logic       init_done_o,
  // Input stream
  input  wire        s_valid_i,
  input  wire beat_data_t s_data_i,
  input  wire beat_keep_t s_keep_i,
  input  wire        s_last_i,
  output logic       s_ready_o,
  // Output stream
  output logic       m_valid_o,
  output beat_data_t m_data_o,
  output beat_keep_t m_keep_o,
  output logic       m_last_o,
  input  wire        m_ready_i
);

  logic                 stream_en;
  logic [NUM_LANES-1:0] lane_push;
  beat_data_t           lane_data;
  beat_keep_t           lane_keep;
  logic                 lane_last;
  logic [NUM_LANES-1:0] credit_ret;

  logic [NUM_LANES-1:0] out_valid;
  beat_data_t           out_data [NUM_LANES];
  beat_keep_t           out_keep [NUM_LANES];
  logic [NUM_LANES-1:0] out_last;
  logic [NUM_LANES-1:0] out_pop;

  assign init_done_o = stream_en;

  init_sequencer u_init_seq (
    .mig_clk             (mig_clk),
    .rst_i               (rst_i),
    .ddr_init_complete_i (ddr_init_complete_i),
    .enable_o            (stream_en)
  );

  lane_dispatch u_dispatch (
    .mig_clk      (mig_clk),
    .rst_i        (rst_i),
    .enable_i     (stream_en),
    .s_valid_i    (s_valid_i),
    .s_data_i     (s_data_i),
    .s_keep_i     (s_keep_i),
    .s_last_i     (s_last_i),
    .s_ready_o    (s_ready_o),
    .credit_ret_i (credit_ret),
    .push_o       (lane_push),
    .data_o       (lane_data),
    .keep_o       (lane_keep),
    .last_o       (lane_last)
  );

  // **********************************************************************
  // Checksum lanes
  // **********************************************************************
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    csum_lane u_lane (
      .mig_clk      (mig_clk),
      .rst_i        (rst_i),
      .push_i       (lane_push[k]),
      .data_i       (lane_data),
      .keep_i       (lane_keep),
      .last_i       (lane_last),
      .credit_ret_o (credit_ret[k]),
      .pop_i        (out_pop[k]),
      .valid_o      (out_valid[k]),
      .data_o       (out_data[k]),
      .keep_o       (out_keep[k]),
      .last_o       (out_last[k])
    );
  end

  lane_collect u_collect (
    .mig_clk      (mig_clk),
    .rst_i        (rst_i),
    .lane_valid_i (out_valid),
    .lane_data_i  (out_data),
    .lane_keep_i  (out_keep),
    .lane_last_i  (out_last),
    .pop_o        (out_pop),
    .m_valid_o    (m_valid_o),
    .m_data_o     (m_data_o),
    .m_keep_o     (m_keep_o),
    .m_last_o     (m_last_o),
    .m_ready_i    (m_ready_i)
  );

endmodule

`default_nettype wire

// File: logic/lane_collect.sv
`timescale 1ns/1ns
`default_nettype none

module lane_collect
  import csum_pkg::*;
(
  input  wire                  mig_clk,
  input  wire                  rst_i,
  // Lane side
  input  wire [NUM_LANES-1:0]  lane_valid_i,
  input  wire beat_data_t      lane_data_i [NUM_LANES],
  input  wire beat_keep_t      lane_keep_i [NUM_LANES],
  input  wire [NUM_LANES-1:0]  lane_last_i,
  output logic [NUM_LANES-1:0] pop_o,
  // Output stream
  output logic                 m_valid_o,
  output beat_data_t           m_data_o,
  output beat_keep_t           m_keep_o,
  output logic                 m_last_o,
  input  wire                  m_ready_i
);

  lane_idx_t cur_lane;   // Follows the dispatcher's order
  logic      out_fire;

  // **********************************************************************
  // Output select
  // **********************************************************************
  assign m_valid_o = lane_valid_i[cur_lane];
  assign m_data_o  = lane_data_i[cur_lane];
  assign m_keep_o  = lane_keep_i[cur_lane];
  assign m_last_o  = lane_last_i[cur_lane];
  assign out_fire  = m_valid_o && m_ready_i;

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      pop_o[k] = m_ready_i && (cur_lane == lane_idx_t'(k));   // Lane gates with its valid
    end
  end

  // **********************************************************************
  // Round-robin advance on packet end
  // **********************************************************************
  always_ff @(posedge mig_clk) begin
    if (rst_i) begin
      cur_lane <= '0;
    end else if (out_fire && m_last_o) begin
      if (cur_lane == lane_idx_t'(NUM_LANES - 1)) begin
        cur_lane <= '0;
      end else begin
        cur_lane <= cur_lane + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/csum_lane.sv
`timescale 1ns/1ns
`default_nettype none

module csum_lane
  import csum_pkg::*;
(
  input  wire        mig_clk,
  input  wire        rst_i,
  // Write side, from the dispatcher
  input  wire        push_i,
  input  wire beat_data_t data_i,
  input  wire beat_keep_t keep_i,
  input  wire        last_i,
  output logic       credit_ret_o,
  // Read side, to the collector
  input  wire        pop_i,
  output logic       valid_o,
  output beat_data_t data_o,
  output beat_keep_t keep_o,
  output logic       last_o
);

  // Packet buffer
  beat_data_t mem_data [LANE_DEPTH];
  beat_keep_t mem_keep [LANE_DEPTH];
  logic       mem_last [LANE_DEPTH];
  csum_t      sum_mem  [LANE_DEPTH];   // Sum kept at the packet's first-beat entry

  buf_addr_t  wr_ptr;
  buf_addr_t  rd_ptr;
  buf_addr_t  pkt_start;               // Entry of the first beat being written
  pkt_cnt_t   pkt_cnt;                 // Complete packets waiting to leave
  logic       first_in;
  logic       first_out;
  csum_t      acc;
  csum_t      acc_next;
  beat_data_t masked;
  logic       pop_beat;
  logic       pkt_in;
  logic       pkt_out;

  function automatic buf_addr_t ptr_inc(input buf_addr_t p);
    if (p == buf_addr_t'(LANE_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Ones' complement add with end-around carry
  function automatic csum_t ones_add(input csum_t a, input csum_t b);
    logic [CSUM_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[CSUM_W-1:0] + csum_t'(s[CSUM_W]);
  endfunction

  // **********************************************************************
  // Checksum accumulation
  // **********************************************************************
  always_comb begin
    for (int b = 0; b < KEEP_W; b++) begin
      masked[8*b +: 8] = keep_i[b] ? data_i[8*b +: 8] : 8'h00;   // Unkept bytes are zero
    end
    acc_next = first_in ? '0 : acc;
    for (int w = 0; w < WORDS_PER_BEAT; w++) begin
      // Checksum field of the first beat counts as zero
      if (!(first_in && (w == 0))) begin
        acc_next = ones_add(acc_next, masked[CSUM_W*w +: CSUM_W]);
      end
    end
  end

  assign pkt_in   = push_i && last_i;
  assign pop_beat = pop_i && valid_o;
  assign pkt_out  = pop_beat && mem_last[rd_ptr];

  always_ff @(posedge mig_clk) begin
    if (push_i) begin
      mem_data[wr_ptr] <= data_i;
      mem_keep[wr_ptr] <= keep_i;
      mem_last[wr_ptr] <= last_i;
      acc              <= acc_next;
      if (first_in) begin
        pkt_start <= wr_ptr;
      end
    end
    if (pkt_in) begin
      sum_mem[first_in ? wr_ptr : pkt_start] <= acc_next;   // Single-beat packet case
    end
  end

  // **********************************************************************
  // Pointers, packet count and credit return
  // **********************************************************************
  always_ff @(posedge mig_clk) begin
    if (rst_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      pkt_cnt      <= '0;
      first_in     <= 1'b1;
      first_out    <= 1'b1;
      credit_ret_o <= 1'b0;
    end else begin
      credit_ret_o <= pop_beat;   // One pulse per beat freed
      if (push_i) begin
        wr_ptr   <= ptr_inc(wr_ptr);
        first_in <= last_i;
      end
      if (pop_beat) begin
        rd_ptr    <= ptr_inc(rd_ptr);
        first_out <= mem_last[rd_ptr];
      end
      pkt_cnt <= pkt_cnt + pkt_cnt_t'(pkt_in) - pkt_cnt_t'(pkt_out);
    end
  end

  // **********************************************************************
  // Output with checksum field rewrite
  // **********************************************************************
  assign valid_o = (pkt_cnt != '0);
  assign keep_o  = mem_keep[rd_ptr];
  assign last_o  = mem_last[rd_ptr];

  always_comb begin
    data_o = mem_data[rd_ptr];
    if (first_out) begin
      data_o[CSUM_W-1:0] = ~sum_mem[rd_ptr];   // Inverted sum into bits 15..0
    end
  end

endmodule

`default_nettype wire

// File: logic/lane_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module lane_dispatch
  import csum_pkg::*;
(
  input  wire                  mig_clk,
  input  wire                  rst_i,
  input  wire                  enable_i,
  // Input stream
  input  wire                  s_valid_i,
  input  wire beat_data_t      s_data_i,
  input  wire beat_keep_t      s_keep_i,
  input  wire                  s_last_i,
  output logic                 s_ready_o,
  // Lane side
  input  wire [NUM_LANES-1:0]  credit_ret_i,
  output logic [NUM_LANES-1:0] push_o,
  output beat_data_t           data_o,
  output beat_keep_t           keep_o,
  output logic                 last_o
);

  credit_t   credit [NUM_LANES];    // Free buffer beats per lane
  lane_idx_t cur_lane;
  logic      beat_fire;

  // **********************************************************************
  // Accept side
  // **********************************************************************
  assign s_ready_o = enable_i && (credit[cur_lane] != '0);
  assign beat_fire = s_valid_i && s_ready_o;

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      push_o[k] = beat_fire && (cur_lane == lane_idx_t'(k));
    end
  end

  // Beat goes to every lane and only the pushed one stores it
  assign data_o = s_data_i;
  assign keep_o = s_keep_i;
  assign last_o = s_last_i;

  // **********************************************************************
  // Credits and lane rotation
  // **********************************************************************
  always_ff @(posedge mig_clk) begin
    if (rst_i) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        credit[k] <= credit_t'(LANE_DEPTH);
      end
      cur_lane <= '0;
    end else begin
      for (int k = 0; k < NUM_LANES; k++) begin
        // Spend and return can land in the same cycle
        credit[k] <= credit[k] - credit_t'(push_o[k]) + credit_t'(credit_ret_i[k]);
      end
      if (beat_fire && s_last_i) begin
        if (cur_lane == lane_idx_t'(NUM_LANES - 1)) begin
          cur_lane <= '0;
        end else begin
          cur_lane <= cur_lane + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/init_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module init_sequencer
  import csum_pkg::*;
(
  input  wire  mig_clk,
  input  wire  rst_i,
  input  wire  ddr_init_complete_i,
  output logic enable_o
);

  init_state_t state;
  init_cnt_t   wait_cnt;    // Cycles seen since init complete

  // Any drop of init complete sends the sequencer back to the start
  always_ff @(posedge mig_clk) begin
    if (rst_i) begin
      state    <= WAIT_MEM;
      wait_cnt <= '0;
    end else if (!ddr_init_complete_i) begin
      state    <= WAIT_MEM;
      wait_cnt <= '0;
    end else begin
      case (state)
        WAIT_MEM: begin
          state    <= COUNT;
          wait_cnt <= init_cnt_t'(1);   // First edge with memory ready
        end
        COUNT: begin
          if (wait_cnt == init_cnt_t'(INIT_WAIT)) begin
            state <= READY;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        READY:   state <= READY;
        default: state <= WAIT_MEM;
      endcase
    end
  end

  assign enable_o = (state == READY);

endmodule

`default_nettype wire

// File: logic/csum_pkg.sv
`default_nettype none

package csum_pkg;

  // **********************************************************************
  // Stream and checksum geometry
  // **********************************************************************
  localparam int DATA_W         = 64;
  localparam int KEEP_W         = DATA_W / 8;        // One keep bit per byte
  localparam int CSUM_W         = 16;
  localparam int WORDS_PER_BEAT = DATA_W / CSUM_W;   // 16-bit words summed per beat

  // **********************************************************************
  // Lane array and init timing
  // **********************************************************************
  localparam int NUM_LANES  = 2;                     // Two parallel checksum paths
  localparam int LANE_DEPTH = 16;                    // Beats per lane, also max packet
  localparam int PKT_SLOTS  = 4;                     // Packets queued in one lane
  localparam int INIT_WAIT  = 15;                    // Cycles from DDR ready to enable

  localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int BUF_AW     = $clog2(LANE_DEPTH);
  localparam int CREDIT_W   = $clog2(LANE_DEPTH + 1);
  localparam int INIT_CNT_W = $clog2(INIT_WAIT + 1);

  typedef logic [DATA_W-1:0]     beat_data_t;
  typedef logic [KEEP_W-1:0]     beat_keep_t;
  typedef logic [CSUM_W-1:0]     csum_t;
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;
  typedef logic [CREDIT_W-1:0]   credit_t;       // 0 up to LANE_DEPTH
  typedef logic [BUF_AW-1:0]     buf_addr_t;
  typedef logic [CREDIT_W-1:0]   pkt_cnt_t;      // Complete packets held in a lane
  typedef logic [INIT_CNT_W-1:0] init_cnt_t;

  typedef enum logic [1:0] {
    WAIT_MEM,
    COUNT,
    READY
  } init_state_t;

endpackage

`default_nettype wire
